// File: gicSys.f
hw/gicPkg.sv
hw/glbIf.sv
hw/gicCfgRegs.sv
hw/gicCtrl.sv
hw/glbBank.sv
hw/gicTop.sv
tb/gicTb.sv

// File: hw/gicCfgRegs.sv
// APB register block holding the transfer setup, raising the start request and the abort pulse
`timescale 1ns/100ps
`default_nettype none

module gicCfgRegs (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // APB slave
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gicPkg::apbAddrW  paddr,
    input  wire gicPkg::apbDatW   pwdata,
    output logic                  pready,
    output gicPkg::apbDatW        prdata,
    output logic                  pslverr,
    // Start request and abort
    output logic                  cfgVld,
    input  wire logic             cfgRdy,
    output logic                  abort,
    // Transfer setup
    output logic                  cfgDir,
    output gicPkg::cntW           cfgNum,
    output gicPkg::dramAddrW      cfgDram,
    output gicPkg::glbAddrW       cfgGlb,
    // Controller status
    input  wire logic             busy,
    input  wire logic             xferDone
);
    import gicPkg::*;

    logic apbAcc;
    logic apbWr;
    logic apbRd;
    logic ctrlWr;
    logic addrHit;
    cntW  doneCnt;

    // ====================
    // APB decode
    // ====================
    assign apbAcc = psel & penable;
    assign apbWr  = apbAcc & pwrite;
    assign apbRd  = apbAcc & ~pwrite;
    assign ctrlWr = apbWr & (paddr == REG_CTRL);

    // No wait states
    assign pready = 1'b1;

    always_comb begin
        case (paddr)
            REG_CTRL, REG_DIR, REG_NUM, REG_DRAM, REG_GLB, REG_STAT: addrHit = 1'b1;
            default: addrHit = 1'b0;
        endcase
    end

    // Unknown offset, or read of write-only control
    assign pslverr = apbAcc & (~addrHit | (apbRd & (paddr == REG_CTRL)));

    // Setup registers, written in the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgDir  <= 1'b0;
            cfgNum  <= '0;
            cfgDram <= '0;
            cfgGlb  <= '0;
        end else if (apbWr) begin
            case (paddr)
                REG_DIR:  cfgDir  <= pwdata[0];
                REG_NUM:  cfgNum  <= pwdata[CNT_W-1:0];
                REG_DRAM: cfgDram <= pwdata[DRAM_ADDR_W-1:0];
                REG_GLB:  cfgGlb  <= pwdata[GLB_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    // ====================
    // Start and abort
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgVld <= 1'b0;
            abort  <= 1'b0;
        end else begin
            // Single-cycle pulse
            abort <= ctrlWr & pwdata[CTRL_ABORT_BIT];
            // Pending until the FSM accepts it
            if (ctrlWr && pwdata[CTRL_START_BIT]) begin
                cfgVld <= 1'b1;
            end else if (cfgVld && cfgRdy) begin
                cfgVld <= 1'b0;
            end
        end
    end

    // Completed transfers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doneCnt <= '0;
        end else if (xferDone) begin
            doneCnt <= doneCnt + 1'b1;
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (apbRd) begin
            case (paddr)
                REG_DIR:  prdata[0]                = cfgDir;
                REG_NUM:  prdata[CNT_W-1:0]        = cfgNum;
                REG_DRAM: prdata[DRAM_ADDR_W-1:0]  = cfgDram;
                REG_GLB:  prdata[GLB_ADDR_W-1:0]   = cfgGlb;
                REG_STAT: begin
                    prdata[STAT_BUSY_BIT]          = busy;
                    prdata[STAT_DONE_LSB +: CNT_W] = doneCnt;
                end
                default: ;
            endcase
        end
    end

    // Start request held across a busy controller
    cfgHoldA: assert property (@(posedge clk) disable iff (!rst_n)
        cfgVld && !cfgRdy |=> cfgVld);

endmodule

`default_nettype wire

// File: hw/gicCtrl.sv
// Transfer FSM of the GIC, sending the command beat and moving words between port and buffer
`timescale 1ns/100ps
`default_nettype none

module gicCtrl (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // Setup from the register block
    input  wire logic              cfgVld,
    output logic                   cfgRdy,
    input  wire logic              abort,
    input  wire logic              cfgDir,
    input  wire gicPkg::cntW       cfgNum,
    input  wire gicPkg::dramAddrW  cfgDram,
    input  wire gicPkg::glbAddrW   cfgGlb,
    output logic                   busy,
    output logic                   xferDone,
    // Off-chip outgoing
    output logic                   itfCmdVld,
    output gicPkg::datW            itfOutDat,
    output logic                   itfOutVld,
    output logic                   itfOutLast,
    input  wire logic              itfOutRdy,
    // Off-chip incoming
    input  wire gicPkg::datW       itfInDat,
    input  wire logic              itfInVld,
    input  wire logic              itfInLast,
    output logic                   itfInRdy,
    // Global buffer
    glbIf.ctrl                     glb
);
    import gicPkg::*;

    gicState state;
    gicState stateNxt;
    datW     cmdWord;
    datW     cmdNxt;
    cntW     addrCnt;
    cntW     retCnt;
    cntW     lastIdx;
    glbAddrW curAddr;
    logic    numZero;
    logic    cmdFire;
    logic    inFire;
    logic    inEnd;
    logic    rdIssue;
    logic    outFire;
    logic    outEnd;
    logic    dataState;

    assign numZero   = (cfgNum == '0);
    assign lastIdx   = cfgNum - 1'b1;
    assign dataState = (state == IN2CHIP) | (state == OUT2OFF);
    assign cmdFire   = (state == CMD) & itfOutRdy;

    // ====================
    // FSM
    // ====================
    always_comb begin
        stateNxt = state;
        case (state)
            IDLE: begin
                if (cfgVld) begin
                    stateNxt = CMD;
                end
            end
            CMD: begin
                if (abort) begin
                    stateNxt = IDLE;
                end else if (cmdFire) begin
                    // Direction from the latched command
                    stateNxt = cmdWord[CMD_DIR_BIT] ? OUT2OFF : IN2CHIP;
                end
            end
            IN2CHIP: begin
                if (abort || numZero || inEnd) begin
                    stateNxt = IDLE;
                end
            end
            OUT2OFF: begin
                if (abort || numZero || outEnd) begin
                    stateNxt = IDLE;
                end
            end
            default: stateNxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= stateNxt;
        end
    end

    assign cfgRdy = (state == IDLE);
    assign busy   = (state != IDLE);

    // Normal completion only, abort suppresses it
    assign xferDone = ~abort & (inEnd | outEnd | (dataState & numZero));

    // Command word packing
    always_comb begin
        cmdNxt                            = '0;
        cmdNxt[CMD_DIR_BIT]               = cfgDir;
        cmdNxt[CMD_DRAM_MSB:CMD_DRAM_LSB] = cfgDram;
        cmdNxt[CMD_NUM_MSB:CMD_NUM_LSB]   = cfgNum;
    end

    // Latched at the start handshake
    always_ff @(posedge clk) begin
        if (state == IDLE && cfgVld) begin
            cmdWord <= cmdNxt;
        end
    end

    // ====================
    // Counters
    // ====================
    // Written beats inbound, issued reads outbound
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addrCnt <= '0;
        end else if (state == IDLE) begin
            addrCnt <= '0;
        end else if (inFire || rdIssue) begin
            addrCnt <= addrCnt + 1'b1;
        end
    end

    // Beats handed to the off-chip side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retCnt <= '0;
        end else if (state == IDLE) begin
            retCnt <= '0;
        end else if (outFire) begin
            retCnt <= retCnt + 1'b1;
        end
    end

    assign curAddr = cfgGlb + addrCnt;

    // Inbound path, straight into the buffer
    assign itfInRdy   = (state == IN2CHIP) & ~numZero & glb.wrRdy;
    assign glb.wrVld  = (state == IN2CHIP) & ~numZero & itfInVld;
    assign glb.wrAddr = curAddr;
    assign glb.wrDat  = itfInDat;
    assign inFire     = itfInVld & itfInRdy;
    assign inEnd      = inFire & ((addrCnt == lastIdx) | itfInLast);

    // Outbound path, reads run ahead of returned beats
    assign glb.rdAddr    = curAddr;
    assign glb.rdAddrVld = (state == OUT2OFF) & (addrCnt < cfgNum);
    assign rdIssue       = glb.rdAddrVld & glb.rdAddrRdy;
    assign glb.rdDatRdy  = (state == OUT2OFF) & itfOutRdy;
    assign outFire       = (state == OUT2OFF) & glb.rdDatVld & itfOutRdy;
    assign outEnd        = outFire & (retCnt == lastIdx);

    // Output port mux
    always_comb begin
        case (state)
            CMD: begin
                itfOutDat  = cmdWord;
                itfOutVld  = 1'b1;
                itfOutLast = 1'b1;
            end
            OUT2OFF: begin
                itfOutDat  = glb.rdDat;
                itfOutVld  = glb.rdDatVld;
                itfOutLast = glb.rdDatVld & (retCnt == lastIdx);
            end
            default: begin
                itfOutDat  = '0;
                itfOutVld  = 1'b0;
                itfOutLast = 1'b0;
            end
        endcase
    end

    assign itfCmdVld = (state == CMD);

    // ====================
    // Checks
    // ====================
    stateLegalA: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state) && (state inside {IDLE, CMD, IN2CHIP, OUT2OFF}));

    // Buffer writes only after a command beat went out
    wrAfterCmdA: assert property (@(posedge clk) disable iff (!rst_n)
        glb.wrVld |-> (state == IN2CHIP) && ($past(state) inside {CMD, IN2CHIP}));

    // Port beat held through back-pressure, bank included
    outHoldA: assert property (@(posedge clk) disable iff (!rst_n)
        itfOutVld && !itfOutRdy && !abort |=> itfOutVld && $stable(itfOutDat));

endmodule

`default_nettype wire

// File: hw/gicPkg.sv
// Shared widths, vector types, FSM encoding and APB register map, imported by every GIC block
`default_nettype none

package gicPkg;

    // ====================
    // Widths
    // ====================
    localparam int DAT_W          = 128;
    localparam int GLB_ADDR_W     = 16;
    localparam int CNT_W          = 16;
    localparam int DRAM_ADDR_W    = 32;
    localparam int APB_ADDR_W     = 8;
    localparam int APB_DAT_W      = 32;

    // Stored buffer entries, address wraps at this depth
    localparam int GLB_DEPTH_LOG2 = 8;
    localparam int GLB_DEPTH      = 1 << GLB_DEPTH_LOG2;

    // Vector types
    typedef logic [DAT_W-1:0]       datW;
    typedef logic [GLB_ADDR_W-1:0]  glbAddrW;
    typedef logic [CNT_W-1:0]       cntW;
    typedef logic [DRAM_ADDR_W-1:0] dramAddrW;
    typedef logic [APB_ADDR_W-1:0]  apbAddrW;
    typedef logic [APB_DAT_W-1:0]   apbDatW;

    // Transfer FSM
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        IN2CHIP,
        OUT2OFF
    } gicState;

    // ====================
    // Register map
    // ====================
    localparam apbAddrW REG_CTRL = 8'h00;
    localparam apbAddrW REG_DIR  = 8'h04;
    localparam apbAddrW REG_NUM  = 8'h08;
    localparam apbAddrW REG_DRAM = 8'h0C;
    localparam apbAddrW REG_GLB  = 8'h10;
    localparam apbAddrW REG_STAT = 8'h14;

    // Control and status bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_ABORT_BIT = 1;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_LSB  = 16;

    // Command word fields, upper bits stay zero
    localparam int CMD_DIR_BIT  = 0;
    localparam int CMD_DRAM_LSB = 1;
    localparam int CMD_DRAM_MSB = CMD_DRAM_LSB + DRAM_ADDR_W - 1;
    localparam int CMD_NUM_LSB  = CMD_DRAM_MSB + 1;
    localparam int CMD_NUM_MSB  = CMD_NUM_LSB + CNT_W - 1;

endpackage

`default_nettype wire

// File: hw/gicTop.sv
// GIC top level joining APB registers, transfer controller and global buffer behind plain ports
`timescale 1ns/100ps
`default_nettype none

module gicTop (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // APB host
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gicPkg::apbAddrW  paddr,
    input  wire gicPkg::apbDatW   pwdata,
    output logic                  pready,
    output gicPkg::apbDatW        prdata,
    output logic                  pslverr,
    // Off-chip outgoing
    output logic                  itfCmdVld,
    output gicPkg::datW           itfOutDat,
    output logic                  itfOutVld,
    output logic                  itfOutLast,
    input  wire logic             itfOutRdy,
    // Off-chip incoming
    input  wire gicPkg::datW      itfInDat,
    input  wire logic             itfInVld,
    input  wire logic             itfInLast,
    output logic                  itfInRdy
);
    import gicPkg::*;

    logic     cfgVld;
    logic     cfgRdy;
    logic     abort;
    logic     cfgDir;
    cntW      cfgNum;
    dramAddrW cfgDram;
    glbAddrW  cfgGlb;
    logic     busy;
    logic     xferDone;

    // Controller to buffer
    glbIf glbBus ();

    // ====================
    // Register block
    // ====================
    gicCfgRegs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .cfgVld   (cfgVld),
        .cfgRdy   (cfgRdy),
        .abort    (abort),
        .cfgDir   (cfgDir),
        .cfgNum   (cfgNum),
        .cfgDram  (cfgDram),
        .cfgGlb   (cfgGlb),
        .busy     (busy),
        .xferDone (xferDone)
    );

    // ====================
    // Controller
    // ====================
    gicCtrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfgVld     (cfgVld),
        .cfgRdy     (cfgRdy),
        .abort      (abort),
        .cfgDir     (cfgDir),
        .cfgNum     (cfgNum),
        .cfgDram    (cfgDram),
        .cfgGlb     (cfgGlb),
        .busy       (busy),
        .xferDone   (xferDone),
        .itfCmdVld  (itfCmdVld),
        .itfOutDat  (itfOutDat),
        .itfOutVld  (itfOutVld),
        .itfOutLast (itfOutLast),
        .itfOutRdy  (itfOutRdy),
        .itfInDat   (itfInDat),
        .itfInVld   (itfInVld),
        .itfInLast  (itfInLast),
        .itfInRdy   (itfInRdy),
        .glb        (glbBus.ctrl)
    );

    // Buffer, abort also empties its read stage
    glbBank bank_i (
        .clk   (clk),
        .rst_n (rst_n),
        .glb   (glbBus.bank),
        .flush (abort)
    );

endmodule

`default_nettype wire

// File: hw/glbBank.sv
// Global-buffer SRAM model with one registered read stage that holds its word under back-pressure
`timescale 1ns/100ps
`default_nettype none

module glbBank (
    input  wire logic clk,
    input  wire logic rst_n,
    glbIf.bank        glb,
    input  wire logic flush
);
    import gicPkg::*;

    datW                       mem [GLB_DEPTH];
    logic [GLB_DEPTH_LOG2-1:0] wrIdx;
    logic [GLB_DEPTH_LOG2-1:0] rdIdx;
    logic                      rdFire;

    // ====================
    // Write side
    // ====================
    // Never stalls
    assign glb.wrRdy = 1'b1;

    // Only the low bits are stored
    assign wrIdx = glb.wrAddr[GLB_DEPTH_LOG2-1:0];

    always_ff @(posedge clk) begin
        if (glb.wrVld && glb.wrRdy) begin
            mem[wrIdx] <= glb.wrDat;
        end
    end

    // ====================
    // Read side
    // ====================
    assign rdIdx = glb.rdAddr[GLB_DEPTH_LOG2-1:0];

    // Output register empty or draining this cycle
    assign glb.rdAddrRdy = ~glb.rdDatVld | glb.rdDatRdy;
    assign rdFire        = glb.rdAddrVld & glb.rdAddrRdy;

    // Read register data
    always_ff @(posedge clk) begin
        if (rdFire) begin
            glb.rdDat <= mem[rdIdx];
        end
    end

    // Read register occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glb.rdDatVld <= 1'b0;
        end else if (flush) begin
            // Drops the held word and any read issued this cycle
            glb.rdDatVld <= 1'b0;
        end else if (rdFire) begin
            glb.rdDatVld <= 1'b1;
        end else if (glb.rdDatRdy) begin
            glb.rdDatVld <= 1'b0;
        end
    end

    // Stalled word stays put until taken
    rdHoldA: assert property (@(posedge clk) disable iff (!rst_n)
        glb.rdDatVld && !glb.rdDatRdy && !flush |=> glb.rdDatVld && $stable(glb.rdDat));

endmodule

`default_nettype wire

// File: hw/glbIf.sv
// Global-buffer bus between controller and SRAM bank, bundling write, read address and read data
`timescale 1ns/100ps
`default_nettype none

interface glbIf;
    import gicPkg::*;

    // Write channel
    glbAddrW wrAddr;
    datW     wrDat;
    logic    wrVld;
    logic    wrRdy;

    // Read address channel
    glbAddrW rdAddr;
    logic    rdAddrVld;
    logic    rdAddrRdy;

    // Read data channel, one register stage in the bank
    datW     rdDat;
    logic    rdDatVld;
    logic    rdDatRdy;

    // Controller side
    modport ctrl (
        output wrAddr, wrDat, wrVld,
        input  wrRdy,
        output rdAddr, rdAddrVld,
        input  rdAddrRdy,
        input  rdDat, rdDatVld,
        output rdDatRdy
    );

    // SRAM side
    modport bank (
        input  wrAddr, wrDat, wrVld,
        output wrRdy,
        input  rdAddr, rdAddrVld,
        output rdAddrRdy,
        output rdDat, rdDatVld,
        input  rdDatRdy
    );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the GIC testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f gicSys.f --top-module gicTb -o gicSim

status=0
./obj_dir/gicSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"

// File: tb/gicTb.sv
// Directed testbench for the GIC, acting as APB host and off-chip agent around gicTop
`timescale 1ns/100ps
`default_nettype none

module gicTb;
    import gicPkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    // Rough cycles per test, register setup included
    localparam int TEST_CYCLES = 25 + 30 + 40 + 90 + 45 + 65;

    logic     clk;
    logic     rst_n;
    logic     psel;
    logic     penable;
    logic     pwrite;
    apbAddrW  paddr;
    apbDatW   pwdata;
    logic     pready;
    apbDatW   prdata;
    logic     pslverr;
    logic     itfCmdVld;
    datW      itfOutDat;
    logic     itfOutVld;
    logic     itfOutLast;
    logic     itfOutRdy;
    datW      itfInDat;
    logic     itfInVld;
    logic     itfInLast;
    logic     itfInRdy;

    // Software copy of the 256-word buffer
    datW      mirror [256];
    int       errCnt;
    int       passCnt;
    int       failCnt;
    int       expDone;

    gicTop dut_i (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .itfCmdVld(itfCmdVld), .itfOutDat(itfOutDat), .itfOutVld(itfOutVld),
        .itfOutLast(itfOutLast), .itfOutRdy(itfOutRdy),
        .itfInDat(itfInDat), .itfInVld(itfInVld), .itfInLast(itfInLast), .itfInRdy(itfInRdy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Checks
    // ====================
    task automatic checkDat(input string name, input datW expV, input datW actV);
        if (actV !== expV) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expV, actV);
            errCnt++;
        end
    endtask

    task automatic checkCnt(input string name, input cntW expV, input cntW actV);
        if (actV !== expV) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expV, actV);
            errCnt++;
        end
    endtask

    task automatic checkReg(input string name, input apbDatW expV, input apbDatW actV);
        if (actV !== expV) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expV, actV);
            errCnt++;
        end
    endtask

    task automatic checkBit(input string name, input logic expV, input logic actV);
        if (actV !== expV) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expV, actV);
            errCnt++;
        end
    endtask

    // ====================
    // Agents
    // ====================
    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Buffer slot, wraps at 256 entries
    function automatic logic [7:0] mirrorIdx(input glbAddrW base, input int off);
        return 8'(int'(base) + off);
    endfunction

    // Setup phase, then access phase sampled mid-cycle
    task automatic apbAccess(input logic wr, input apbAddrW addr, input apbDatW wdat,
                             output apbDatW rdat, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdat;
        nextCycle();
        penable = 1'b1;
        @(negedge clk);
        // No wait states on this slave
        checkBit("pready", 1'b1, pready);
        rdat = prdata;
        err  = pslverr;
        nextCycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrW addr, input apbDatW wdat);
        apbDatW rd;
        logic   err;
        apbAccess(1'b1, addr, wdat, rd, err);
        checkBit("pslverr", 1'b0, err);
    endtask

    task automatic apbRead(input apbAddrW addr, output apbDatW rdat, output logic err);
        apbAccess(1'b0, addr, '0, rdat, err);
    endtask

    task automatic checkStat(input logic expBusy);
        apbDatW rd;
        logic   err;
        apbRead(REG_STAT, rd, err);
        checkBit("busy", expBusy, rd[0]);
        checkCnt("doneCnt", cntW'(expDone), rd[31:16]);
    endtask

    // Programs one transfer and takes the command beat
    task automatic startXfer(input logic dir, input cntW num, input dramAddrW dram,
                             input glbAddrW base);
        datW cmdExp;
        // Dir at bit 0, DRAM base above it, word count on top
        cmdExp        = '0;
        cmdExp[0]     = dir;
        cmdExp[32:1]  = dram;
        cmdExp[48:33] = num;
        apbWrite(REG_DIR, {31'd0, dir});
        apbWrite(REG_NUM, {16'd0, num});
        apbWrite(REG_DRAM, dram);
        apbWrite(REG_GLB, {16'd0, base});
        apbWrite(REG_CTRL, 32'h1);
        itfOutRdy = 1'b1;
        @(negedge clk);
        while (!itfOutVld) @(negedge clk);
        checkBit("itfCmdVld", 1'b1, itfCmdVld);
        checkBit("itfOutLast", 1'b1, itfOutLast);
        checkDat("itfOutDat", cmdExp, itfOutDat);
        nextCycle();
        itfOutRdy = 1'b0;
    endtask

    // Inbound beats, optional early last at index lastAt
    task automatic sendBeats(input glbAddrW base, input int n, input int lastAt);
        datW dat;
        for (int i = 0; i < n; i++) begin
            dat       = {$urandom, $urandom, $urandom, $urandom};
            itfInDat  = dat;
            itfInVld  = 1'b1;
            itfInLast = (i == lastAt);
            @(negedge clk);
            while (!itfInRdy) @(negedge clk);
            nextCycle();
            mirror[mirrorIdx(base, i)] = dat;
        end
        itfInVld  = 1'b0;
        itfInLast = 1'b0;
        // Idle right after the closing beat
        @(negedge clk);
        checkBit("itfInRdy", 1'b0, itfInRdy);
        nextCycle();
    endtask

    // Outbound beats under random back-pressure
    task automatic recvBeats(input glbAddrW base, input int n);
        int got;
        got = 0;
        while (got < n) begin
            itfOutRdy = ($urandom % 4) != 0;
            @(negedge clk);
            if (itfOutVld && itfOutRdy) begin
                checkBit("itfCmdVld", 1'b0, itfCmdVld);
                checkDat("itfOutDat", mirror[mirrorIdx(base, got)], itfOutDat);
                checkBit("itfOutLast", got == n - 1, itfOutLast);
                got++;
            end
            nextCycle();
        end
        itfOutRdy = 1'b0;
        // Nothing after the last word
        @(negedge clk);
        checkBit("itfOutVld", 1'b0, itfOutVld);
        nextCycle();
    endtask

    task automatic endTest(input string name, input int errStart);
        if (errCnt == errStart) begin
            passCnt++;
            $display("%s: ok", name);
        end else begin
            failCnt++;
            $display("%s: %0d errors", name, errCnt - errStart);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic testRegs();
        apbDatW rd;
        logic   err;
        int     errStart;
        errStart = errCnt;
        @(negedge clk);
        checkBit("itfOutVld", 1'b0, itfOutVld);
        checkBit("itfCmdVld", 1'b0, itfCmdVld);
        checkBit("itfInRdy", 1'b0, itfInRdy);
        nextCycle();
        apbWrite(REG_DIR, 32'h1);
        apbWrite(REG_NUM, 32'h0000_1234);
        apbWrite(REG_DRAM, 32'hdead_beef);
        apbWrite(REG_GLB, 32'h0000_00ab);
        apbRead(REG_DIR, rd, err);
        checkReg("REG_DIR", 32'h1, rd);
        checkBit("pslverr", 1'b0, err);
        apbRead(REG_NUM, rd, err);
        checkReg("REG_NUM", 32'h0000_1234, rd);
        apbRead(REG_DRAM, rd, err);
        checkReg("REG_DRAM", 32'hdead_beef, rd);
        apbRead(REG_GLB, rd, err);
        checkReg("REG_GLB", 32'h0000_00ab, rd);
        checkStat(1'b0);
        // Undefined offset and write-only control
        apbRead(8'h18, rd, err);
        checkBit("pslverr", 1'b1, err);
        apbRead(REG_CTRL, rd, err);
        checkBit("pslverr", 1'b1, err);
        endTest("register readback", errStart);
    endtask

    task automatic testInbound();
        int errStart;
        errStart = errCnt;
        startXfer(1'b0, 16'd12, 32'h1000_0000, 16'h0020);
        sendBeats(16'h0020, 12, -1);
        expDone++;
        checkStat(1'b0);
        endTest("inbound 12 words", errStart);
    endtask

    task automatic testOutbound();
        int errStart;
        errStart = errCnt;
        startXfer(1'b1, 16'd12, 32'h1000_0000, 16'h0020);
        recvBeats(16'h0020, 12);
        expDone++;
        checkStat(1'b0);
        endTest("outbound 12 words", errStart);
    endtask

    task automatic testEarlyEnd();
        int errStart;
        errStart = errCnt;
        // Known old contents first
        startXfer(1'b0, 16'd10, 32'h0000_4000, 16'h0040);
        sendBeats(16'h0040, 10, -1);
        expDone++;
        startXfer(1'b0, 16'd10, 32'h0000_4100, 16'h0040);
        sendBeats(16'h0040, 4, 3);
        expDone++;
        checkStat(1'b0);
        startXfer(1'b1, 16'd4, 32'h0000_4200, 16'h0040);
        recvBeats(16'h0040, 4);
        expDone++;
        startXfer(1'b1, 16'd6, 32'h0000_4300, 16'h0044);
        recvBeats(16'h0044, 6);
        expDone++;
        checkStat(1'b0);
        endTest("early last beat", errStart);
    endtask

    task automatic testAbort();
        int errStart;
        errStart = errCnt;
        startXfer(1'b1, 16'd20, 32'h0000_5000, 16'h0020);
        // Bank holds a stalled word
        repeat (4) nextCycle();
        apbWrite(REG_CTRL, 32'h2);
        checkStat(1'b0);
        startXfer(1'b1, 16'd3, 32'h0000_5100, 16'h0020);
        recvBeats(16'h0020, 3);
        expDone++;
        checkStat(1'b0);
        endTest("abort outbound", errStart);
    endtask

    task automatic testWrap();
        int errStart;
        errStart = errCnt;
        startXfer(1'b0, 16'd4, 32'h0000_6000, 16'h00fe);
        sendBeats(16'h00fe, 4, -1);
        expDone++;
        startXfer(1'b1, 16'd4, 32'h0000_6000, 16'h00fe);
        recvBeats(16'h00fe, 4);
        expDone++;
        // Wrapped words land at the bottom of the buffer
        startXfer(1'b1, 16'd2, 32'h0000_6100, 16'h0000);
        recvBeats(16'h0000, 2);
        expDone++;
        checkStat(1'b0);
        endTest("address wrap", errStart);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'h84e3_0b73));
        errCnt    = 0;
        passCnt   = 0;
        failCnt   = 0;
        expDone   = 0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        itfOutRdy = 1'b0;
        itfInDat  = '0;
        itfInVld  = 1'b0;
        itfInLast = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        nextCycle();
        testRegs();
        testInbound();
        testOutbound();
        testEarlyEnd();
        testAbort();
        testWrap();
        $display("Tests passed %0d, failed %0d, check errors %0d", passCnt, failCnt, errCnt);
        if (failCnt == 0 && errCnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Hang guard, four times the expected run
    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding",
                 TEST_CYCLES * 4);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
